//--- src/id_pkg.sv
`default_nettype none

package id_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////////////////////

    localparam int XLEN       = 32;
    localparam int NUM_REGS   = 32;
    localparam int REG_AW     = $clog2(NUM_REGS);
    localparam int NUM_RPORTS = 4;

    // instruction buffer, counted per bank
    localparam int BUF_DEPTH  = 16;
    localparam int FULL_LEVEL = 15;
    localparam int PTR_W      = $clog2(BUF_DEPTH);
    localparam int CNT_W      = $clog2(BUF_DEPTH + 1);

    ////////////////////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////////////////////

    // 3R format, opcode in bits 31..15
    localparam logic [16:0] OPC_ADD_W = 17'h00020;
    localparam logic [16:0] OPC_SUB_W = 17'h00022;
    localparam logic [16:0] OPC_AND   = 17'h00029;
    localparam logic [16:0] OPC_OR    = 17'h0002a;
    localparam logic [16:0] OPC_XOR   = 17'h0002b;

    // 2RI12 format, opcode in bits 31..22
    localparam logic [9:0]  OPC_ADDI_W = 10'h00a;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR
    } alu_op_e;

    // subset of the architectural ecode values
    typedef enum logic [7:0] {
        NONE = 8'd0,
        ADEF = 8'd8,
        INE  = 8'd13
    } ecode_e;

    ////////////////////////////////////////////////////////////////////////////
    // bundles
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     ir;
        ecode_e          ecode;
    } fetch_slot_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        alu_op_e           op;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rj;
        logic [REG_AW-1:0] rk;
        logic [XLEN-1:0]   imm;      // sign-extended si12
        logic              use_imm;
        logic              we;
        ecode_e            ecode;
    } uop_t;

    // also used as the commit report
    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [REG_AW-1:0] rd;
        logic              we;
        logic [XLEN-1:0]   wdata;
        ecode_e            ecode;
    } exec_result_t;

endpackage

`default_nettype wire

//--- src/inst_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module inst_buffer (
    input  wire                      clk,
    input  wire                      rstn,
    input  wire id_pkg::fetch_slot_t i_slot0,
    input  wire id_pkg::fetch_slot_t i_slot1,
    input  wire [1:0]                i_valid,
    input  wire                      i_stall,
    input  wire                      i_flush,
    output id_pkg::fetch_slot_t      o_slot0,
    output id_pkg::fetch_slot_t      o_slot1,
    output logic [1:0]               o_valid,
    output logic                     o_full
);

    // two interleaved banks, bank index 0/1
    id_pkg::fetch_slot_t            bank_mem [2][id_pkg::BUF_DEPTH];
    logic [id_pkg::PTR_W-1:0]       head     [2];
    logic [id_pkg::PTR_W-1:0]       tail     [2];
    logic [id_pkg::CNT_W-1:0]       count    [2];

    logic                           wr_sel;  // bank for the next older write
    logic                           rd_sel;  // bank holding the oldest entry
    logic [1:0]                     wr_en;
    logic [1:0]                     rd_en;
    logic [1:0]                     not_empty;
    id_pkg::fetch_slot_t            wr_data  [2];

    ////////////////////////////////////////////////////////////////////////////
    // write steering
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        wr_en      = 2'b00;
        wr_data[0] = i_slot0;
        wr_data[1] = i_slot0;
        // flush drops whatever fetch offers this cycle
        if (!i_flush && i_valid[1]) begin
            wr_en[wr_sel] = 1'b1;
        end
        if (!i_flush && i_valid == 2'b11) begin
            wr_en[!wr_sel]   = 1'b1;
            wr_data[!wr_sel] = i_slot1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read side
    ////////////////////////////////////////////////////////////////////////////

    assign not_empty[0] = (count[0] != '0);
    assign not_empty[1] = (count[1] != '0);

    // everything presented leaves at the next edge
    assign rd_en = o_valid[1] ? not_empty : 2'b00;

    always_comb begin
        if (i_stall || i_flush) begin
            o_valid = 2'b00;
        end else if (&not_empty) begin
            o_valid = 2'b11;
        end else if (|not_empty) begin
            o_valid = 2'b10;
        end else begin
            o_valid = 2'b00;
        end
    end

    // oldest first, the other bank holds the next one
    assign o_slot0 = bank_mem[rd_sel][head[rd_sel]];
    assign o_slot1 = bank_mem[!rd_sel][head[!rd_sel]];

    assign o_full = (count[0] >= id_pkg::FULL_LEVEL) || (count[1] >= id_pkg::FULL_LEVEL);

    ////////////////////////////////////////////////////////////////////////////
    // state
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int b = 0; b < 2; b++) begin
                head[b]  <= '0;
                tail[b]  <= '0;
                count[b] <= '0;
            end
            wr_sel <= 1'b0;
            rd_sel <= 1'b0;
        end else if (i_flush) begin
            for (int b = 0; b < 2; b++) begin
                head[b]  <= '0;
                tail[b]  <= '0;
                count[b] <= '0;
            end
            wr_sel <= 1'b0;
            rd_sel <= 1'b0;
        end else begin
            for (int b = 0; b < 2; b++) begin
                if (wr_en[b]) begin
                    tail[b] <= tail[b] + 1'b1;
                end
                if (rd_en[b]) begin
                    head[b] <= head[b] + 1'b1;
                end
                case ({wr_en[b], rd_en[b]})
                    2'b10:   count[b] <= count[b] + 1'b1;
                    2'b01:   count[b] <= count[b] - 1'b1;
                    default: count[b] <= count[b];
                endcase
            end
            // a single write fills one bank only, so the next goes to the other
            if (i_valid == 2'b10) begin
                wr_sel <= !wr_sel;
            end
            if (^rd_en) begin
                rd_sel <= !rd_sel;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < 2; b++) begin
            if (wr_en[b]) begin
                bank_mem[b][tail[b]] <= wr_data[b];
            end
        end
    end

    // fetch must hold off on o_full well before a bank overflows
    for (genvar b = 0; b < 2; b++) begin : g_chk
        a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
            wr_en[b] |-> (count[b] != id_pkg::BUF_DEPTH))
            else $error("write into full bank %0d", b);
    end

endmodule

`default_nettype wire

//--- src/inst_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module inst_decoder (
    input  wire id_pkg::fetch_slot_t i_slot,
    input  wire                      i_valid,
    output id_pkg::uop_t             o_uop
);

    logic [31:0] ir;
    logic        matched;

    assign ir = i_slot.ir;

    always_comb begin
        o_uop         = '0;
        matched       = 1'b1;
        o_uop.valid   = i_valid;
        o_uop.pc      = i_slot.pc;

        // field positions are the same for 3R and 2RI12
        o_uop.rd      = ir[4:0];
        o_uop.rj      = ir[9:5];
        o_uop.rk      = ir[14:10];
        o_uop.imm     = {{20{ir[21]}}, ir[21:10]};
        o_uop.use_imm = 1'b0;
        o_uop.op      = id_pkg::ADD;

        if (ir[31:22] == id_pkg::OPC_ADDI_W) begin
            o_uop.op      = id_pkg::ADD;
            o_uop.use_imm = 1'b1;
        end else begin
            case (ir[31:15])
                id_pkg::OPC_ADD_W: o_uop.op = id_pkg::ADD;
                id_pkg::OPC_SUB_W: o_uop.op = id_pkg::SUB;
                id_pkg::OPC_AND:   o_uop.op = id_pkg::AND;
                id_pkg::OPC_OR:    o_uop.op = id_pkg::OR;
                id_pkg::OPC_XOR:   o_uop.op = id_pkg::XOR;
                default:           matched  = 1'b0;
            endcase
        end

        // a fetch exception wins over an illegal encoding
        if (i_slot.ecode != id_pkg::NONE) begin
            o_uop.ecode = i_slot.ecode;
        end else if (!matched) begin
            o_uop.ecode = id_pkg::INE;
        end else begin
            o_uop.ecode = id_pkg::NONE;
        end

        // no write for exceptions or for r0
        o_uop.we = i_valid
                && matched
                && (i_slot.ecode == id_pkg::NONE)
                && (o_uop.rd != '0);
    end

endmodule

`default_nettype wire

//--- src/alu_exec.sv
`timescale 1ns/1ns
`default_nettype none

module alu_exec (
    input  wire id_pkg::uop_t                                         i_uop0,
    input  wire id_pkg::uop_t                                         i_uop1,
    input  wire [id_pkg::NUM_RPORTS-1:0][id_pkg::XLEN-1:0]            i_rdata,
    output logic [id_pkg::NUM_RPORTS-1:0][id_pkg::REG_AW-1:0]         o_raddr,
    output id_pkg::exec_result_t                                      o_res0,
    output id_pkg::exec_result_t                                      o_res1
);

    logic [id_pkg::XLEN-1:0] src_b0;
    logic [id_pkg::XLEN-1:0] src_a1;
    logic [id_pkg::XLEN-1:0] rk_val1;
    logic [id_pkg::XLEN-1:0] src_b1;
    logic [id_pkg::XLEN-1:0] val0;
    logic [id_pkg::XLEN-1:0] val1;
    logic                    fwd_en;

    function automatic logic [id_pkg::XLEN-1:0] alu_calc(
        input id_pkg::alu_op_e         op,
        input logic [id_pkg::XLEN-1:0] a,
        input logic [id_pkg::XLEN-1:0] b
    );
        case (op)
            id_pkg::SUB: return a - b;
            id_pkg::AND: return a & b;
            id_pkg::OR:  return a | b;
            id_pkg::XOR: return a ^ b;
            default:     return a + b;
        endcase
    endfunction

    // wdata reads as zero whenever nothing is written
    function automatic id_pkg::exec_result_t pack_result(
        input id_pkg::uop_t            u,
        input logic [id_pkg::XLEN-1:0] val
    );
        id_pkg::exec_result_t r;
        r.valid = u.valid;
        r.pc    = u.pc;
        r.rd    = u.rd;
        r.we    = u.we;
        r.wdata = u.we ? val : '0;
        r.ecode = u.ecode;
        return r;
    endfunction

    // ports 0/1 serve lane 0, ports 2/3 lane 1
    assign o_raddr[0] = i_uop0.rj;
    assign o_raddr[1] = i_uop0.rk;
    assign o_raddr[2] = i_uop1.rj;
    assign o_raddr[3] = i_uop1.rk;

    assign src_b0 = i_uop0.use_imm ? i_uop0.imm : i_rdata[1];
    assign val0   = alu_calc(i_uop0.op, i_rdata[0], src_b0);

    // lane 0 result bypasses the register file into lane 1
    assign fwd_en  = i_uop0.valid && i_uop0.we;
    assign src_a1  = (fwd_en && i_uop0.rd == i_uop1.rj) ? val0 : i_rdata[2];
    assign rk_val1 = (fwd_en && i_uop0.rd == i_uop1.rk) ? val0 : i_rdata[3];
    assign src_b1  = i_uop1.use_imm ? i_uop1.imm : rk_val1;
    assign val1    = alu_calc(i_uop1.op, src_a1, src_b1);

    assign o_res0 = pack_result(i_uop0, val0);
    assign o_res1 = pack_result(i_uop1, val1);

    // the buffer always fills slot 0 first
    always_comb begin
        a_lane_order: assert final (!i_uop1.valid || i_uop0.valid)
            else $error("lane 1 valid without lane 0");
    end

endmodule

`default_nettype wire

//--- src/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  wire                                                clk,
    input  wire                                                rstn,
    input  wire [id_pkg::NUM_RPORTS-1:0][id_pkg::REG_AW-1:0]   i_raddr,
    input  wire id_pkg::exec_result_t                          i_res0,
    input  wire id_pkg::exec_result_t                          i_res1,
    output logic [id_pkg::NUM_RPORTS-1:0][id_pkg::XLEN-1:0]    o_rdata,
    output id_pkg::exec_result_t                               o_commit0,
    output id_pkg::exec_result_t                               o_commit1
);

    logic [id_pkg::XLEN-1:0] regs [id_pkg::NUM_REGS];

    // r0 reads as zero
    always_comb begin
        for (int p = 0; p < id_pkg::NUM_RPORTS; p++) begin
            o_rdata[p] = (i_raddr[p] == '0) ? '0 : regs[i_raddr[p]];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int r = 0; r < id_pkg::NUM_REGS; r++) begin
                regs[r] <= '0;
            end
            o_commit0 <= '0;
            o_commit1 <= '0;
        end else begin
            if (i_res0.valid && i_res0.we && i_res0.rd != '0) begin
                regs[i_res0.rd] <= i_res0.wdata;
            end
            // lane 1 is younger, so it wins on the same rd
            if (i_res1.valid && i_res1.we && i_res1.rd != '0) begin
                regs[i_res1.rd] <= i_res1.wdata;
            end
            o_commit0 <= i_res0;
            o_commit1 <= i_res1;
        end
    end

    // decode clears we for r0 targets
    a_no_r0_write: assert property (@(posedge clk) disable iff (!rstn)
        ((i_res0.valid && i_res0.we) |-> i_res0.rd != '0)
        and ((i_res1.valid && i_res1.we) |-> i_res1.rd != '0))
        else $error("write enable on r0");

endmodule

`default_nettype wire

//--- src/id_core_top.sv
`timescale 1ns/1ns
`default_nettype none

module id_core_top (
    input  wire                      clk,
    input  wire                      rstn,
    input  wire id_pkg::fetch_slot_t i_slot0,
    input  wire id_pkg::fetch_slot_t i_slot1,
    input  wire [1:0]                i_valid,
    input  wire                      i_stall,
    input  wire                      i_flush,
    output logic                     o_full,
    output id_pkg::exec_result_t     o_commit0,
    output id_pkg::exec_result_t     o_commit1
);

    id_pkg::fetch_slot_t                                 out_slot0;
    id_pkg::fetch_slot_t                                 out_slot1;
    logic [1:0]                                          out_valid;
    id_pkg::uop_t                                        uop0;
    id_pkg::uop_t                                        uop1;
    id_pkg::exec_result_t                                res0;
    id_pkg::exec_result_t                                res1;
    logic [id_pkg::NUM_RPORTS-1:0][id_pkg::REG_AW-1:0]   raddr;
    logic [id_pkg::NUM_RPORTS-1:0][id_pkg::XLEN-1:0]     rdata;

    inst_buffer buf_i (
        .clk     (clk),
        .rstn    (rstn),
        .i_slot0 (i_slot0),
        .i_slot1 (i_slot1),
        .i_valid (i_valid),
        .i_stall (i_stall),
        .i_flush (i_flush),
        .o_slot0 (out_slot0),
        .o_slot1 (out_slot1),
        .o_valid (out_valid),
        .o_full  (o_full)
    );

    // out_valid[1] marks the older slot
    inst_decoder dec0_i (.i_slot(out_slot0), .i_valid(out_valid[1]), .o_uop(uop0));
    inst_decoder dec1_i (.i_slot(out_slot1), .i_valid(out_valid[0]), .o_uop(uop1));

    alu_exec alu_i (
        .i_uop0  (uop0),
        .i_uop1  (uop1),
        .i_rdata (rdata),
        .o_raddr (raddr),
        .o_res0  (res0),
        .o_res1  (res1)
    );

    reg_file rf_i (
        .clk       (clk),
        .rstn      (rstn),
        .i_raddr   (raddr),
        .i_res0    (res0),
        .i_res1    (res1),
        .o_rdata   (rdata),
        .o_commit0 (o_commit0),
        .o_commit1 (o_commit1)
    );

endmodule

`default_nettype wire

//--- tb/clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clk_gen (
    output logic o_clk
);

    // 8 ns period
    localparam int HALF_PERIOD = 4;

    initial begin
        o_clk = 1'b0;
        forever begin
            #(HALF_PERIOD) o_clk = ~o_clk;
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_id_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_id_core;

    // instruction kinds known to the model
    localparam logic [2:0] K_ADD  = 3'd0;
    localparam logic [2:0] K_SUB  = 3'd1;
    localparam logic [2:0] K_AND  = 3'd2;
    localparam logic [2:0] K_OR   = 3'd3;
    localparam logic [2:0] K_XOR  = 3'd4;
    localparam logic [2:0] K_ADDI = 3'd5;
    localparam logic [2:0] K_ILL  = 3'd6;
    localparam int DRAIN_LIMIT    = 100;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] ir;
        logic [7:0]  ecode;
        logic [2:0]  kind;
    } pend_t;

    logic                 clk;
    logic                 rstn;
    id_pkg::fetch_slot_t  slot0;
    id_pkg::fetch_slot_t  slot1;
    logic [1:0]           valid_in;
    logic                 stall;
    logic                 flush;
    logic                 full;
    id_pkg::exec_result_t commit0;
    id_pkg::exec_result_t commit1;

    // accepted and not flushed, in program order
    pend_t       pending [$];
    logic [31:0] model_regs [id_pkg::NUM_REGS];
    logic [31:0] pc_next;
    int          errors;
    int          checks;
    int          last_occ;
    logic        last_hold;
    logic        hung;
    int          stall_left;
    int          pct_pair;
    int          pct_single;
    int          pct_stall;
    int          pct_flush;
    int          pct_bad;
    int          reg_span;

    clk_gen clk_i (.o_clk(clk));

    id_core_top dut_i (
        .clk       (clk),
        .rstn      (rstn),
        .i_slot0   (slot0),
        .i_slot1   (slot1),
        .i_valid   (valid_in),
        .i_stall   (stall),
        .i_flush   (flush),
        .o_full    (full),
        .o_commit0 (commit0),
        .o_commit1 (commit1)
    );

    ////////////////////////////////////////////////////////////////////////////
    // model helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic int rand_below(input int n);
        return $urandom % n;
    endfunction

    function automatic logic [31:0] model_alu(input logic [2:0] kind, input logic [31:0] a,
                                              input logic [31:0] b);
        case (kind)
            K_SUB:   return a - b;
            K_AND:   return a & b;
            K_OR:    return a | b;
            K_XOR:   return a ^ b;
            default: return a + b;
        endcase
    endfunction

    function automatic bit is_legal(input logic [31:0] ir);
        logic [16:0] opc;
        opc = ir[31:15];
        return (ir[31:22] == id_pkg::OPC_ADDI_W) || (opc == id_pkg::OPC_ADD_W)
            || (opc == id_pkg::OPC_SUB_W) || (opc == id_pkg::OPC_AND)
            || (opc == id_pkg::OPC_OR) || (opc == id_pkg::OPC_XOR);
    endfunction

    function automatic logic [31:0] encode(input logic [2:0] kind, input logic [4:0] rd,
                                           input logic [4:0] rj, input logic [4:0] rk,
                                           input logic [11:0] si12);
        logic [31:0] ir;
        case (kind)
            K_ADD:   ir = {id_pkg::OPC_ADD_W, rk, rj, rd};
            K_SUB:   ir = {id_pkg::OPC_SUB_W, rk, rj, rd};
            K_AND:   ir = {id_pkg::OPC_AND, rk, rj, rd};
            K_OR:    ir = {id_pkg::OPC_OR, rk, rj, rd};
            K_XOR:   ir = {id_pkg::OPC_XOR, rk, rj, rd};
            K_ADDI:  ir = {id_pkg::OPC_ADDI_W, si12, rj, rd};
            default: begin
                // random words, skipping the few that decode
                ir = $urandom;
                while (is_legal(ir)) begin
                    ir = $urandom;
                end
            end
        endcase
        return ir;
    endfunction

    task automatic make_slot(output id_pkg::fetch_slot_t s, output pend_t p);
        int roll;
        roll    = rand_below(100);
        p.kind  = (roll < pct_bad) ? K_ILL : 3'(rand_below(6));
        p.ecode = (roll >= pct_bad && roll < 2 * pct_bad) ? 8'd8 : 8'd0;
        p.pc    = pc_next;
        p.ir    = encode(p.kind, 5'(rand_below(reg_span)), 5'(rand_below(reg_span)),
                         5'(rand_below(reg_span)), 12'($urandom));
        pc_next = pc_next + 32'd4;
        s.pc    = p.pc;
        s.ir    = p.ir;
        s.ecode = id_pkg::ecode_e'(p.ecode);
    endtask

    task automatic compare(input string name, input string field, input logic [31:0] exp,
                           input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED %s: %s expected %h got %h", name, field, exp, act);
        end
    endtask

    // sequential execution of the oldest pending instruction
    task automatic check_commit(input string name, input id_pkg::exec_result_t c);
        pend_t       p;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] val;
        logic [4:0]  rd;
        logic [7:0]  ecode;
        logic        we;
        if (pending.size() == 0) begin
            errors++;
            $display("%s: commit at pc %h with no instruction pending", name, c.pc);
            return;
        end
        p     = pending.pop_front();
        rd    = p.ir[4:0];
        a     = model_regs[p.ir[9:5]];
        b     = (p.kind == K_ADDI) ? {{20{p.ir[21]}}, p.ir[21:10]} : model_regs[p.ir[14:10]];
        val   = model_alu(p.kind, a, b);
        ecode = (p.ecode != 8'd0) ? p.ecode : ((p.kind == K_ILL) ? 8'd13 : 8'd0);
        we    = (ecode == 8'd0) && (rd != 5'd0);
        compare(name, "pc", p.pc, c.pc);
        compare(name, "rd", 32'(rd), 32'(c.rd));
        compare(name, "we", 32'(we), 32'(c.we));
        compare(name, "wdata", we ? val : 32'd0, c.wdata);
        compare(name, "ecode", 32'(ecode), 32'(c.ecode));
        if (we) begin
            model_regs[rd] = val;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // one cycle, check then drive
    ////////////////////////////////////////////////////////////////////////////

    task automatic step(input string name);
        id_pkg::fetch_slot_t s0;
        id_pkg::fetch_slot_t s1;
        pend_t               p0;
        pend_t               p1;
        int                  got;
        int                  roll;
        @(negedge clk);
        got = int'(commit0.valid) + int'(commit1.valid);
        if (commit1.valid && !commit0.valid) begin
            errors++;
            $display("%s: commit on lane 1 without lane 0", name);
        end
        // up to two leave per edge, none while held
        compare(name, "commit count", 32'(last_hold ? 0 : (last_occ < 2 ? last_occ : 2)),
                32'(got));
        if (commit0.valid) begin
            check_commit(name, commit0);
        end
        if (commit1.valid) begin
            check_commit(name, commit1);
        end
        // banks alternate, so the fuller one holds ceil(n/2)
        compare(name, "o_full", 32'((pending.size() + 1) / 2 >= id_pkg::FULL_LEVEL),
                32'(full));

        if (stall_left > 0) begin
            stall_left--;
        end else if (rand_below(100) < pct_stall) begin
            stall_left = 1 + rand_below(40);
        end
        stall    = (stall_left > 0);
        flush    = (rand_below(100) < pct_flush);
        roll     = rand_below(100);
        valid_in = 2'b00;
        if (!full && roll < pct_pair) begin
            valid_in = 2'b11;
        end else if (!full && roll < pct_pair + pct_single) begin
            valid_in = 2'b10;
        end
        if (valid_in[1]) begin
            make_slot(s0, p0);
            slot0 = s0;
        end
        if (valid_in[0]) begin
            make_slot(s1, p1);
            slot1 = s1;
        end
        last_occ  = pending.size();
        last_hold = stall || flush;
        if (flush) begin
            pending.delete();
        end else begin
            if (valid_in[1]) begin
                pending.push_back(p0);
            end
            if (valid_in[0]) begin
                pending.push_back(p1);
            end
        end
    endtask

    task automatic run_phase(input string name, input int cycles, input int pair,
                             input int single, input int stl, input int fl, input int bad,
                             input int span);
        int i;
        int waited;
        if (hung) begin
            return;
        end
        pct_pair   = pair;
        pct_single = single;
        pct_stall  = stl;
        pct_flush  = fl;
        pct_bad    = bad;
        reg_span   = span;
        for (i = 0; i < cycles; i++) begin
            step(name);
        end
        // drain with fetch idle
        pct_pair   = 0;
        pct_single = 0;
        pct_stall  = 0;
        pct_flush  = 0;
        stall_left = 0;
        waited     = 0;
        while (pending.size() != 0 && !hung) begin
            if (waited == DRAIN_LIMIT) begin
                hung = 1'b1;
                $display("%s: timeout, %0d instructions never committed", name,
                         pending.size());
            end else begin
                step(name);
                waited++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int seed_ret;
        seed_ret   = $urandom(32'h393a);
        rstn       = 1'b0;
        slot0      = '0;
        slot1      = '0;
        valid_in   = 2'b00;
        stall      = 1'b0;
        flush      = 1'b0;
        pc_next    = 32'h1c00_0000;
        errors     = 0;
        checks     = 0;
        last_occ   = 0;
        last_hold  = 1'b1;
        hung       = 1'b0;
        stall_left = 0;
        for (int r = 0; r < id_pkg::NUM_REGS; r++) begin
            model_regs[r] = 32'd0;
        end
        repeat (8) @(negedge clk);
        rstn = 1'b1;

        run_phase("random_stream", 300, 40, 30, 0, 0, 0, 8);
        run_phase("single_burst", 200, 0, 85, 0, 0, 0, 8);
        run_phase("stall", 400, 60, 25, 8, 0, 0, 16);
        run_phase("flush", 300, 45, 30, 5, 4, 0, 16);
        run_phase("exceptions", 300, 40, 30, 3, 0, 20, 32);

        $display("checks: %0d  errors: %0d  timeout: %0d", checks, errors, hung);
        if (errors == 0 && !hung) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
src/id_pkg.sv
src/inst_buffer.sv
src/inst_decoder.sv
src/alu_exec.sv
src/reg_file.sv
src/id_core_top.sv
tb/clk_gen.sv
tb/tb_id_core.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tb_id_core \
    -f build.f -o sim_id_core \
    && ./obj_dir/sim_id_core | tee /dev/stderr | grep -q "Done: no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
